//--- efi_arg_buffer.sv
`timescale 1ns/1ps

module efi_arg_buffer import efi_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  efi_word_t arg,
    input  logic      arg_valid,
    output logic      arg_ready,
    input  logic      pop,
    output efi_word_t head,
    output logic      head_valid
);

    efi_word_t mem [BUF_DEPTH];

    logic [BUF_PTR_WIDTH-1:0] wr_ptr;
    logic [BUF_PTR_WIDTH-1:0] rd_ptr;
    logic [BUF_CNT_WIDTH-1:0] count;

    logic push_en;
    logic pop_en;

    assign arg_ready = count < BUF_CNT_WIDTH'(BUF_DEPTH);
    assign head_valid = count != '0;
    assign head = mem[rd_ptr];

    assign push_en = arg_valid && arg_ready;
    // A pop on an empty buffer would corrupt the count, so it is ignored
    assign pop_en = pop && head_valid;

    always_ff @(posedge clock) begin
        if (push_en) begin
            mem[wr_ptr] <= arg;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the occupancy where it was
            case ({push_en, pop_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- efi_float_unit.sv
`timescale 1ns/1ps

module efi_float_unit import efi_pkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    input  efi_word_t             head,
    input  logic                  load,
    input  logic                  pack,
    input  logic [QUOT_WIDTH-1:0] quot,
    output logic [MANT_WIDTH-1:0] mant,
    output efi_word_t             res
);

    fp32_t   op;
    fclass_e op_class;

    fclass_e               cls_q;
    logic                  sign_q;
    logic [EXP_WIDTH-1:0]  exp_q;
    logic [DEST_WIDTH-1:0] dest_q;
    logic                  last_q;

    logic [EXP_WIDTH-1:0]  exp_base;
    logic [DATA_WIDTH-1:0] res_data;

    assign op = fp32_t'(head.data);

    // The divider captures this in the same cycle as load
    assign mant = {1'b1, op.frac};

    always_comb begin
        if (op.exp == '0) begin
            op_class = FC_ZERO;
        end else if (op.exp == EXP_ALL_ONES) begin
            op_class = (op.frac == '0) ? FC_INF : FC_NAN;
        end else begin
            op_class = FC_NORMAL;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            cls_q <= FC_ZERO;
        end else if (load) begin
            cls_q <= op_class;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            sign_q <= op.sign;
            exp_q <= op.exp;
            dest_q <= head.dest;
            last_q <= head.last;
        end
    end

    // Quotient bit 24 is set only for a mantissa of exactly 2**23
    assign exp_base = quot[QUOT_WIDTH-1] ? RECIP_EXP_POW2 : RECIP_EXP;

    always_comb begin
        case (cls_q)
            FC_NAN: res_data = CANONICAL_NAN;
            FC_ZERO: res_data = {sign_q, EXP_ALL_ONES, {FRAC_WIDTH{1'b0}}};
            FC_INF: res_data = {sign_q, {(DATA_WIDTH - 1){1'b0}}};
            default: begin
                if (exp_q >= exp_base) begin
                    // Flush to zero when the result exponent would underflow
                    res_data = {sign_q, {(DATA_WIDTH - 1){1'b0}}};
                end else begin
                    res_data = {sign_q, exp_base - exp_q, quot[FRAC_WIDTH-1:0]};
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            res <= '0;
        end else if (pack) begin
            res <= '{data: res_data, dest: dest_q, last: last_q};
        end
    end

endmodule

//--- efi_mant_divider.sv
`timescale 1ns/1ps

module efi_mant_divider import efi_pkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  load,
    input  logic                  step,
    input  logic [MANT_WIDTH-1:0] mant,
    output logic [QUOT_WIDTH-1:0] quot
);

    logic [MANT_WIDTH-1:0] divisor;
    logic [QUOT_WIDTH-1:0] rem;

    logic                  rem_ge;
    logic [QUOT_WIDTH-1:0] rem_next;

    // Restoring step: subtract only when the partial remainder covers the divisor
    assign rem_ge = rem >= {1'b0, divisor};
    assign rem_next = rem_ge ? rem - {1'b0, divisor} : rem;

    always_ff @(posedge clock) begin
        if (rst) begin
            divisor <= '0;
            rem <= '0;
            quot <= '0;
        end else if (load) begin
            divisor <= mant;
            rem <= DIV_REM_INIT;
            quot <= '0;
        end else if (step) begin
            // rem_next is below the divisor, so its top bit is always clear
            rem <= {rem_next[QUOT_WIDTH-2:0], 1'b0};
            quot <= {quot[QUOT_WIDTH-2:0], rem_ge};
        end
    end

endmodule

//--- efi_pkg.sv
package efi_pkg;

    // Stream and word widths
    localparam int DATA_WIDTH = 32;
    localparam int DEST_WIDTH = 8;

    // The argument buffer depth is a power of two so the pointers wrap by themselves
    localparam int BUF_DEPTH = 4;
    localparam int BUF_PTR_WIDTH = $clog2(BUF_DEPTH);
    localparam int BUF_CNT_WIDTH = $clog2(BUF_DEPTH + 1);

    // One quotient bit per divide step
    localparam int DIV_STEPS = 25;
    localparam int STEP_CNT_WIDTH = $clog2(DIV_STEPS + 1);

    // Single precision field widths
    localparam int EXP_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int MANT_WIDTH = FRAC_WIDTH + 1;
    localparam int QUOT_WIDTH = DIV_STEPS;

    // The divider starts from the top 24 bits of 2**47, which equal 2**23
    localparam logic [QUOT_WIDTH-1:0] DIV_REM_INIT = QUOT_WIDTH'(1) << FRAC_WIDTH;

    // Result exponents before the operand exponent is subtracted
    localparam logic [EXP_WIDTH-1:0] RECIP_EXP_POW2 = 8'd254;
    localparam logic [EXP_WIDTH-1:0] RECIP_EXP = 8'd253;
    localparam logic [EXP_WIDTH-1:0] EXP_ALL_ONES = 8'hFF;

    localparam logic [DATA_WIDTH-1:0] CANONICAL_NAN = 32'h7FC00000;

    // One word on either stream
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DEST_WIDTH-1:0] dest;
        logic                  last;
    } efi_word_t;

    // Fields of a single precision operand
    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp;
        logic [FRAC_WIDTH-1:0] frac;
    } fp32_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DIVIDE,
        ST_PACK,
        ST_SEND
    } recip_state_e;

    typedef enum logic [1:0] {
        FC_NORMAL,
        FC_ZERO,
        FC_INF,
        FC_NAN
    } fclass_e;

endpackage

//--- efi_recip_fsm.sv
`timescale 1ns/1ps

module efi_recip_fsm import efi_pkg::*; (
    input  logic clock,
    input  logic rst,
    input  logic head_valid,
    input  logic count_done,
    input  logic res_ready,
    output logic pop,
    output logic load,
    output logic step,
    output logic count_start,
    output logic pack,
    output logic res_valid
);

    recip_state_e state;
    recip_state_e next_state;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (head_valid) begin
                    next_state = ST_LOAD;
                end
            end
            // Operand is taken from the buffer head in this single cycle
            ST_LOAD: begin
                next_state = ST_DIVIDE;
            end
            ST_DIVIDE: begin
                if (count_done) begin
                    next_state = ST_PACK;
                end
            end
            ST_PACK: begin
                next_state = ST_SEND;
            end
            ST_SEND: begin
                if (res_ready) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Every control pulse follows from the state alone
    assign pop = state == ST_LOAD;
    assign load = state == ST_LOAD;
    assign count_start = state == ST_LOAD;
    assign step = state == ST_DIVIDE;
    assign pack = state == ST_PACK;

    // The result register is held until the consumer takes it
    assign res_valid = state == ST_SEND;

endmodule

//--- efi_reciprocal.sv
`timescale 1ns/1ps

module efi_reciprocal import efi_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  efi_word_t arg,
    input  logic      arg_valid,
    output logic      arg_ready,
    output efi_word_t res,
    output logic      res_valid,
    input  logic      res_ready
);

    efi_word_t head;
    logic      head_valid;

    logic pop;
    logic load;
    logic step;
    logic count_start;
    logic count_done;
    logic pack;

    logic [MANT_WIDTH-1:0] mant;
    logic [QUOT_WIDTH-1:0] quot;

    // Operands queue here while an earlier one is still in the divider
    efi_arg_buffer u_arg_buffer (
        .clock      (clock),
        .rst        (rst),
        .arg        (arg),
        .arg_valid  (arg_valid),
        .arg_ready  (arg_ready),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid)
    );

    efi_recip_fsm u_recip_fsm (
        .clock       (clock),
        .rst         (rst),
        .head_valid  (head_valid),
        .count_done  (count_done),
        .res_ready   (res_ready),
        .pop         (pop),
        .load        (load),
        .step        (step),
        .count_start (count_start),
        .pack        (pack),
        .res_valid   (res_valid)
    );

    efi_step_counter u_step_counter (
        .clock (clock),
        .rst   (rst),
        .start (count_start),
        .step  (step),
        .done  (count_done)
    );

    efi_mant_divider u_mant_divider (
        .clock (clock),
        .rst   (rst),
        .load  (load),
        .step  (step),
        .mant  (mant),
        .quot  (quot)
    );

    efi_float_unit u_float_unit (
        .clock (clock),
        .rst   (rst),
        .head  (head),
        .load  (load),
        .pack  (pack),
        .quot  (quot),
        .mant  (mant),
        .res   (res)
    );

endmodule

//--- efi_reciprocal_asserts.sv
`timescale 1ns/1ps

module efi_reciprocal_asserts import efi_pkg::*; (
    input logic                     clock,
    input logic                     rst,
    input efi_word_t                res,
    input logic                     res_valid,
    input logic                     res_ready,
    input logic                     arg_ready,
    input logic [BUF_CNT_WIDTH-1:0] buf_count,
    input recip_state_e             state
);

    // A waiting result stays put until the consumer takes it
    res_held: assert property (
        @(posedge clock) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res)
    ) else $error("res changed or dropped while res_ready was low");

    buf_full_stalls: assert property (
        @(posedge clock) disable iff (rst)
        buf_count == BUF_CNT_WIDTH'(BUF_DEPTH) |-> !arg_ready
    ) else $error("arg_ready is high with the buffer full");

    // Only the send state may offer a result
    valid_only_in_send: assert property (
        @(posedge clock) disable iff (rst)
        state != ST_SEND |-> !res_valid
    ) else $error("res_valid is high outside ST_SEND");

    valid_low_after_reset: assert property (
        @(posedge clock)
        rst |=> !res_valid
    ) else $error("res_valid is high right after reset");

endmodule

//--- efi_reciprocal_tb.sv
`timescale 1ns/1ps

module efi_reciprocal_tb import efi_pkg::*; ();

    localparam int NUM_OPS = 300;
    localparam int NUM_DIRECTED = 20;
    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY_CYCLES = 27;
    localparam int STALL_CYCLES = 16;
    localparam int TIMEOUT_NS = NUM_OPS * (LATENCY_CYCLES + STALL_CYCLES) * CLK_PERIOD_NS * 2;
    localparam int DRAIN_CYCLES = (BUF_DEPTH + 2) * (LATENCY_CYCLES + STALL_CYCLES);
    localparam logic [31:0] LFSR_SEED = 32'h5152;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic      clock;
    logic      rst;
    efi_word_t arg;
    logic      arg_valid;
    logic      arg_ready;
    efi_word_t res;
    logic      res_valid;
    logic      res_ready;

    logic [31:0] lfsr_state;
    efi_word_t   expected_q [$];
    int          accepted;
    int          checked;

    efi_reciprocal u_efi_reciprocal (
        .clock     (clock),
        .rst       (rst),
        .arg       (arg),
        .arg_valid (arg_valid),
        .arg_ready (arg_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    bind efi_reciprocal efi_reciprocal_asserts u_efi_reciprocal_asserts (
        .clock     (clock),
        .rst       (rst),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .arg_ready (arg_ready),
        .buf_count (u_arg_buffer.count),
        .state     (u_recip_fsm.state)
    );

    always #(CLK_PERIOD_NS / 2) clock = ~clock;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Galois LFSR stepped once for every bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
        end
        return v;
    endfunction

    // Corner operands that open the run
    function automatic logic [31:0] directed_operand(input int idx);
        case (idx)
            0: return 32'h3F800000;
            1: return 32'hBF800000;
            2: return 32'h40000000;
            3: return 32'h00800000;
            4: return 32'h7F000000;
            5: return 32'h7F400000;
            6: return 32'h7E800001;
            7: return 32'hFE800001;
            8: return 32'h7E800000;
            9: return 32'h00000000;
            10: return 32'h80000000;
            11: return 32'h00000001;
            12: return 32'h807FFFFF;
            13: return 32'h7F800000;
            14: return 32'hFF800000;
            15: return 32'h7FC00000;
            16: return 32'hFFFFFFFF;
            17: return 32'h7F800001;
            18: return 32'h3FFFFFFF;
            default: return 32'h40490FDB;
        endcase
    endfunction

    // Mostly normal operands with exponent 1 to 253 and now and then any bit pattern
    function automatic logic [31:0] random_operand();
        logic       sign;
        logic [7:0] exp;
        if (take_bits(3) == 0) begin
            return take_bits(32);
        end
        sign = 1'(take_bits(1));
        exp = 8'(1 + take_bits(8) % 253);
        return {sign, exp, 23'(take_bits(23))};
    endfunction

    function automatic efi_word_t recip_ref(input efi_word_t w);
        logic        s;
        logic [7:0]  e;
        logic [22:0] f;
        logic [63:0] q;
        int          re;
        efi_word_t   r;
        s = w.data[31];
        e = w.data[30:23];
        f = w.data[22:0];
        r.dest = w.dest;
        r.last = w.last;
        if (e == 8'hFF && f != 0) begin
            r.data = 32'h7FC00000;
        end else if (e == 8'hFF) begin
            r.data = {s, 31'b0};
        end else if (e == 0) begin
            r.data = {s, 8'hFF, 23'b0};
        end else begin
            q = (64'd1 << 47) / {40'b0, 1'b1, f};
            re = (f == 0) ? 254 - int'(e) : 253 - int'(e);
            if (re <= 0) begin
                r.data = {s, 31'b0};
            end else begin
                r.data = {s, 8'(re), (f == 0) ? 23'b0 : q[22:0]};
            end
        end
        return r;
    endfunction

    initial begin : stimulus
        int        issued;
        int        gap_left;
        int        pkt_left;
        int        hold_left;
        int        drain_left;
        efi_word_t word;

        clock = 1'b0;
        rst = 1'b1;
        arg = '0;
        arg_valid = 1'b0;
        res_ready = 1'b0;
        lfsr_state = LFSR_SEED;
        accepted = 0;
        checked = 0;
        issued = 0;
        gap_left = 0;
        pkt_left = 0;
        hold_left = 0;
        drain_left = 0;

        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;

        // Idle unit after reset
        repeat (4) begin
            @(posedge clock);
            assert (!res_valid) else stop_on_error("res_valid went high before any operand");
            assert (arg_ready) else stop_on_error("arg_ready is low with an empty buffer");
        end

        while (accepted < NUM_OPS) begin
            @(posedge clock);
            if (arg_valid && arg_ready) begin
                expected_q.push_back(recip_ref(arg));
                accepted++;
            end
            // The next word goes out only once the current one has been taken
            if (!arg_valid || arg_ready) begin
                if (issued == NUM_OPS || gap_left > 0) begin
                    arg_valid <= 1'b0;
                    if (gap_left > 0) begin
                        gap_left--;
                    end
                end else begin
                    if (pkt_left == 0) begin
                        pkt_left = 1 + take_bits(3) % 6;
                    end
                    word.data = (issued < NUM_DIRECTED) ? directed_operand(issued)
                                                        : random_operand();
                    word.dest = 8'(take_bits(8));
                    word.last = pkt_left == 1;
                    pkt_left--;
                    issued++;
                    arg <= word;
                    arg_valid <= 1'b1;
                    gap_left = (take_bits(2) == 0) ? take_bits(2) : 0;
                end
            end
            if (hold_left > 0) begin
                hold_left--;
                res_ready <= 1'b0;
            end else if (take_bits(3) == 0) begin
                hold_left = take_bits(4);
                res_ready <= 1'b0;
            end else begin
                res_ready <= 1'b1;
            end
        end

        // Words still buffered or in the divider come out within a bounded time
        res_ready <= 1'b1;
        drain_left = DRAIN_CYCLES;
        while (checked < NUM_OPS && drain_left > 0) begin
            @(posedge clock);
            drain_left--;
        end

        // Leave room for a surplus result to show up
        repeat (2 * LATENCY_CYCLES) @(posedge clock);
        assert (expected_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d results are missing at the end of the run",
                                    expected_q.size()));
        end
    end

    always @(posedge clock) begin : result_check
        efi_word_t expected_word;
        if (!rst && res_valid && res_ready) begin
            assert (expected_q.size() > 0)
                else stop_on_error("A result came out with no operand waiting for it");
            expected_word = expected_q.pop_front();
            assert (res.data == expected_word.data)
                else stop_on_error($sformatf("Fail res.data expected %08h actual %08h",
                                             expected_word.data, res.data));
            assert (res.dest == expected_word.dest)
                else stop_on_error($sformatf("Fail res.dest expected %02h actual %02h",
                                             expected_word.dest, res.dest));
            assert (res.last == expected_word.last)
                else stop_on_error($sformatf("Fail res.last expected %0h actual %0h",
                                             expected_word.last, res.last));
            checked++;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_on_error("Timeout while waiting for results from the DUT");
    end

endmodule

//--- efi_step_counter.sv
`timescale 1ns/1ps

module efi_step_counter import efi_pkg::*; (
    input  logic clock,
    input  logic rst,
    input  logic start,
    input  logic step,
    output logic done
);

    logic [STEP_CNT_WIDTH-1:0] count;

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // Count holds the number of steps already taken, so the last one sees DIV_STEPS - 1
    assign done = step && (count == STEP_CNT_WIDTH'(DIV_STEPS - 1));

endmodule

//--- flist.f
efi_pkg.sv
efi_arg_buffer.sv
efi_recip_fsm.sv
efi_step_counter.sv
efi_mant_divider.sv
efi_float_unit.sv
efi_reciprocal.sv
efi_reciprocal_asserts.sv
efi_reciprocal_tb.sv
